// ==== hdl/ringPkg.sv ====
package ringPkg;

	// tile geometry
	localparam int tileBytes = 16;
	localparam int tileShift = $clog2(tileBytes);	// byte offset bits inside a tile

	// local storage sizes in tiles
	localparam int romTiles = 2048;
	localparam int ramTiles = 512;
	localparam int romIdxW = $clog2(romTiles);	// 11 bits
	localparam int ramIdxW = $clog2(ramTiles);	// 9 bits

	// fill patterns for the two synthetic pages
	localparam logic [127:0] nopTile = {8{16'h3000}};
	localparam logic [127:0] rtsTile = {8{16'h3010}};

	// opm status nibble values
	localparam logic [3:0] errStatus = 4'hB;
	localparam logic [3:0] flagsAll = 4'hF;	// kept as is on an error reply

	// upper opcode nibble of a control command
	localparam logic [3:0] ctrlNibble = 4'h8;

	// ring opcodes in the low byte of opm
	typedef enum logic [7:0]
	{
		opIdle = 8'h00,
		opLoad = 8'h10,
		opLoadC = 8'h11,
		opStore = 8'h12,
		opStoreC = 8'h13,
		opPrefetch = 8'h14,
		opPrefetchS = 8'h15,
		okLoad = 8'h60,
		okStore = 8'h61
	} ringOp;

	// what decode makes of the opcode
	typedef enum logic [2:0]
	{
		clsOther,
		clsLoad,
		clsStore,
		clsPrefetch,
		clsCtrl
	} opClass;

	// which part of the low 256K the address falls in
	typedef enum logic [2:0]
	{
		regNone,
		regRom,
		regRam,
		regZero,
		regNop,
		regRts
	} memRegion;

	// one message slot on the ring
	typedef struct packed
	{
		logic [15:0] seq;	// source node in the top byte
		logic [15:0] opm;	// opcode in the low byte and flags in 11:8
		logic [31:0] addr;
		logic [127:0] data;
	} ringMsg;

	// message plus decode results carried down the pipeline
	typedef struct packed
	{
		ringMsg msg;
		opClass cls;
		memRegion region;
		logic badAddr;	// request with addr bits 31:30 set
	} decodedMsg;

endpackage

// ==== hdl/ringDecode.sv ====
`timescale 1ns/1ps

module ringDecode
(
	input logic clock,
	input logic rst,
	input ringPkg::ringMsg msgIn,
	output ringPkg::decodedMsg decoded
);

	ringPkg::opClass cls;
	ringPkg::memRegion region;
	logic lowSpace;	// addr bits 31:18 all zero
	logic isReq;
	logic badAddr;

	// opcode class
	always_comb
	begin
		case (msgIn.opm[7:0])
			ringPkg::opLoad, ringPkg::opLoadC:
				cls = ringPkg::clsLoad;
			ringPkg::opStore, ringPkg::opStoreC:
				cls = ringPkg::clsStore;
			ringPkg::opPrefetch, ringPkg::opPrefetchS:
				cls = ringPkg::clsPrefetch;
			ringPkg::opIdle, ringPkg::okLoad, ringPkg::okStore:
				cls = ringPkg::clsOther;	// idle slots and replies just travel on
			default:
			begin
				if (msgIn.opm[7:4] == ringPkg::ctrlNibble)
					cls = ringPkg::clsCtrl;
				else
					cls = ringPkg::clsOther;
			end
		endcase
	end

	assign isReq = (cls == ringPkg::clsLoad) ||
		(cls == ringPkg::clsStore) ||
		(cls == ringPkg::clsPrefetch);

	// top two address bits set on a request is an error
	assign badAddr = isReq && (msgIn.addr[31:30] != 2'b00);

	assign lowSpace = (msgIn.addr[31:18] == 14'd0);

	// region map over bits 17:13
	always_comb
	begin
		region = ringPkg::regNone;
		if (lowSpace)
		begin
			if (msgIn.addr[17:15] == 3'b000)
				region = ringPkg::regRom;	// 0000..7FFF
			else if (msgIn.addr[17:13] == 5'b00110)
				region = ringPkg::regRam;	// C000..DFFF
			else if (msgIn.addr[17:16] == 2'b01)
				region = ringPkg::regZero;
			else if (msgIn.addr[17:16] == 2'b10)
				region = ringPkg::regNop;
			else if (msgIn.addr[17:16] == 2'b11)
				region = ringPkg::regRts;
			// 8000..BFFF and E000..FFFF have nothing behind them
		end
	end

	// stage register
	always_ff @(posedge clock)
	begin
		decoded.msg.seq <= msgIn.seq;
		decoded.msg.addr <= msgIn.addr;
		decoded.msg.data <= msgIn.data;
		if (rst)
		begin
			decoded.msg.opm <= {8'h00, ringPkg::opIdle};
			decoded.cls <= ringPkg::clsOther;
			decoded.region <= ringPkg::regNone;
			decoded.badAddr <= 1'b0;
		end
		else
		begin
			decoded.msg.opm <= msgIn.opm;
			decoded.cls <= cls;
			decoded.region <= region;
			decoded.badAddr <= badAddr;
		end
	end

endmodule

// ==== hdl/tileStore.sv ====
`timescale 1ns/1ps

module tileStore
(
	input logic clock,
	input logic rst,
	input ringPkg::decodedMsg decoded,
	output ringPkg::decodedMsg executed,
	output logic [127:0] tileData
);

	logic [127:0] romArray [0:ringPkg::romTiles-1];
	logic [127:0] ramArray [0:ringPkg::ramTiles-1];

	logic [ringPkg::romIdxW-1:0] romIdx;
	logic [ringPkg::ramIdxW-1:0] ramIdx;
	logic ramWrite;

	logic [127:0] romRead;	// registered ROM tile
	logic [127:0] ramRead;	// registered SRAM tile with old contents on a store

	// boot image covers only the first tiles and the rest stays zero
	initial
	begin
		for (int i = 0; i < ringPkg::romTiles; i++)
			romArray[i] = '0;
		$readmemh("romImage.hex", romArray);
	end

	// tile indices straight from the registered address
	assign romIdx = decoded.msg.addr[ringPkg::tileShift +: ringPkg::romIdxW];	// bits 14:4
	assign ramIdx = decoded.msg.addr[ringPkg::tileShift +: ringPkg::ramIdxW];	// bits 12:4

	assign ramWrite = (decoded.cls == ringPkg::clsStore) &&
		(decoded.region == ringPkg::regRam);

	// ROM port
	always_ff @(posedge clock)
	begin
		romRead <= romArray[romIdx];
	end

	// SRAM port reads before it writes on the same edge
	always_ff @(posedge clock)
	begin
		ramRead <= ramArray[ramIdx];
		if (ramWrite)
			ramArray[ramIdx] <= decoded.msg.data;
	end

	// message moves along with the read
	always_ff @(posedge clock)
	begin
		executed.msg.seq <= decoded.msg.seq;
		executed.msg.addr <= decoded.msg.addr;
		executed.msg.data <= decoded.msg.data;
		if (rst)
		begin
			executed.msg.opm <= {8'h00, ringPkg::opIdle};
			executed.cls <= ringPkg::clsOther;
			executed.region <= ringPkg::regNone;
			executed.badAddr <= 1'b0;
		end
		else
		begin
			executed.msg.opm <= decoded.msg.opm;
			executed.cls <= decoded.cls;
			executed.region <= decoded.region;
			executed.badAddr <= decoded.badAddr;
		end
	end

	// pick the tile for the region
	always_comb
	begin
		case (executed.region)
			ringPkg::regRom:
				tileData = romRead;
			ringPkg::regRam:
				tileData = ramRead;
			ringPkg::regNop:
				tileData = ringPkg::nopTile;
			ringPkg::regRts:
				tileData = ringPkg::rtsTile;
			ringPkg::regZero:
				tileData = '0;
			default:
				tileData = '0;	// nothing local
		endcase
	end

endmodule

// ==== hdl/ringResult.sv ====
`timescale 1ns/1ps

module ringResult
(
	input logic clock,
	input logic rst,
	input ringPkg::decodedMsg executed,
	input logic [127:0] tileData,
	output ringPkg::ringMsg msgOut
);

	logic isReq;
	logic isLocal;
	ringPkg::ringMsg nextMsg;

	assign isReq = (executed.cls == ringPkg::clsLoad) ||
		(executed.cls == ringPkg::clsStore) ||
		(executed.cls == ringPkg::clsPrefetch);

	assign isLocal = (executed.region != ringPkg::regNone);

	// reply or forward
	always_comb
	begin
		nextMsg = executed.msg;	// default is pass-through
		if (isReq && executed.badAddr)
		begin
			// an all-ones flag nibble survives the error reply
			nextMsg.opm[7:0] = ringPkg::okLoad;
			if (executed.msg.opm[11:8] == ringPkg::flagsAll)
				nextMsg.opm[11:8] = ringPkg::flagsAll;
			else
				nextMsg.opm[11:8] = ringPkg::errStatus;
			nextMsg.data = '0;
		end
		else if (isReq && isLocal)
		begin
			if (executed.cls == ringPkg::clsStore)
				nextMsg.opm[7:0] = ringPkg::okStore;
			else
				nextMsg.opm[7:0] = ringPkg::okLoad;
			nextMsg.data = tileData;	// old tile for a store
		end
		else if (executed.cls == ringPkg::clsCtrl)
		begin
			nextMsg.opm[7:0] = ringPkg::okLoad;	// plain ack with flags kept
			nextMsg.data = '0;
		end
	end

	// back onto the ring
	always_ff @(posedge clock)
	begin
		msgOut.seq <= nextMsg.seq;
		msgOut.addr <= nextMsg.addr;
		msgOut.data <= nextMsg.data;
		if (rst)
			msgOut.opm <= {8'h00, ringPkg::opIdle};
		else
			msgOut.opm <= nextMsg.opm;
	end

endmodule

// ==== hdl/tileRomNode.sv ====
`timescale 1ns/1ps

module tileRomNode
(
	input logic clock,
	input logic rst,
	input ringPkg::ringMsg msgIn,
	output ringPkg::ringMsg msgOut
);

	ringPkg::decodedMsg decoded;	// decode to execute
	ringPkg::decodedMsg executed;	// execute to result
	logic [127:0] tileData;

	// classify and register the incoming slot
	ringDecode decodeStage
	(
		.clock(clock),
		.rst(rst),
		.msgIn(msgIn),
		.decoded(decoded)
	);

	// ROM and SRAM access
	tileStore storeStage
	(
		.clock(clock),
		.rst(rst),
		.decoded(decoded),
		.executed(executed),
		.tileData(tileData)
	);

	// build the reply or forward
	ringResult resultStage
	(
		.clock(clock),
		.rst(rst),
		.executed(executed),
		.tileData(tileData),
		.msgOut(msgOut)
	);

endmodule

// ==== bench/tileRomNodeTb.sv ====
`timescale 1ns/1ps

module tileRomNodeTb;

	// one golden line with stimulus and expected output
	typedef struct packed
	{
		ringPkg::ringMsg stim;
		ringPkg::ringMsg want;
		logic maskData;	// store replies carry the old tile
		logic [7:0] testNum;
	} goldenVec;

	// an output the ring still owes
	typedef struct packed
	{
		ringPkg::ringMsg want;
		logic maskData;
		logic lastOfTest;	// closing idle of a group
		logic [7:0] testNum;
		logic [31:0] dueCycle;
	} expEntry;

	logic clock;
	logic rst;
	ringPkg::ringMsg msgIn;
	ringPkg::ringMsg msgOut;

	goldenVec goldens[$];
	expEntry expQueue[$];
	logic [31:0] cycleCount;	// cycles since reset release
	int checkCount [0:255];
	int errCount [0:255];
	int checkTotal;
	int errorTotal;
	int loadErrors;
	int testsRun;
	int testsPassed;
	int drainCycles;
	logic timedOut;

	tileRomNode uut
	(
		.clock(clock),
		.rst(rst),
		.msgIn(msgIn),
		.msgOut(msgOut)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#2 clock = ~clock;
	end

	function automatic string testName(input logic [7:0] t);
		case (t)
			8'd1: return "rom loads and prefetches";
			8'd2: return "sram store then load";
			8'd3: return "zero, nop and rts pages";
			8'd4: return "error replies and control acks";
			8'd5: return "pass-through traffic";
			8'd6: return "idle after reset";
			default: return "unknown";
		endcase
	endfunction

	task automatic countError(input logic [7:0] t);
		errCount[t]++;
		errorTotal++;
	endtask

	task automatic reportTest(input logic [7:0] t);
		testsRun++;
		if (errCount[t] == 0)
		begin
			testsPassed++;
			$display("test %0d %s: pass, %0d messages", t, testName(t), checkCount[t]);
		end
		else
			$display("test %0d %s: fail, %0d mismatches in %0d messages", t, testName(t),
				errCount[t], checkCount[t]);
	endtask

	// read all vectors up front and skip lines starting with #
	task automatic readGolden();
		int fd;
		int code;
		int fields;
		string line;
		goldenVec g;
		logic [15:0] inSeq, inOpm, outSeq, outOpm;
		logic [31:0] inAddr, outAddr;
		logic [127:0] inData, outData;
		logic [7:0] testNum;
		logic maskFlag;
		fd = $fopen("bench/tileRomGolden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open bench/tileRomGolden.txt");
			loadErrors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line.getc(0) != "#")
				begin
					fields = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h", testNum, maskFlag,
						inSeq, inOpm, inAddr, inData, outSeq, outOpm, outAddr, outData);
					if (fields != 10 || testNum < 1 || testNum > 5)
					begin
						$display("golden line not understood: %s", line);
						loadErrors++;
					end
					else
					begin
						g.stim = {inSeq, inOpm, inAddr, inData};
						g.want = {outSeq, outOpm, outAddr, outData};
						g.maskData = maskFlag;
						g.testNum = testNum;
						goldens.push_back(g);
					end
				end
			end
			$fclose(fd);
			if (goldens.size() == 0)
			begin
				$display("golden file holds no vectors");
				loadErrors++;
			end
		end
	endtask

	task automatic checkEntry(input expEntry e);
		assert (msgOut.seq === e.want.seq)
		else
		begin
			$display("FAILED t=%0t test %0d msgOut.seq: got %h expected %h", $time, e.testNum,
				msgOut.seq, e.want.seq);
			countError(e.testNum);
		end
		assert (msgOut.opm === e.want.opm)
		else
		begin
			$display("FAILED t=%0t test %0d msgOut.opm: got %h expected %h", $time, e.testNum,
				msgOut.opm, e.want.opm);
			countError(e.testNum);
		end
		assert (msgOut.addr === e.want.addr)
		else
		begin
			$display("FAILED t=%0t test %0d msgOut.addr: got %h expected %h", $time, e.testNum,
				msgOut.addr, e.want.addr);
			countError(e.testNum);
		end
		if (!e.maskData)
		begin
			assert (msgOut.data === e.want.data)
			else
			begin
				$display("FAILED t=%0t test %0d msgOut.data: got %h expected %h", $time,
					e.testNum, msgOut.data, e.want.data);
				countError(e.testNum);
			end
		end
		checkCount[e.testNum]++;
		checkTotal++;
		if (e.lastOfTest)
			reportTest(e.testNum);
	endtask

	task automatic checkDue();
		expEntry e;
		if (expQueue.size() > 0 && expQueue[0].dueCycle == cycleCount)
		begin
			e = expQueue.pop_front();
			checkEntry(e);
		end
		else
		begin
			// nothing in flight yet so the ring must read idle
			assert (msgOut.opm[7:0] === ringPkg::opIdle)
			else
			begin
				$display("FAILED t=%0t test 6 msgOut.opm[7:0]: got %h expected %h", $time,
					msgOut.opm[7:0], ringPkg::opIdle);
				countError(8'd6);
			end
			checkCount[6]++;
			checkTotal++;
		end
	endtask

	task automatic driveMsg(input ringPkg::ringMsg stim, input ringPkg::ringMsg want,
		input logic mask, input logic [7:0] testNum, input logic last);
		expEntry e;
		msgIn = stim;
		e.want = want;
		e.maskData = mask;
		e.lastOfTest = last;
		e.testNum = testNum;
		e.dueCycle = cycleCount + 3;	// three stage registers
		expQueue.push_back(e);
	endtask

	// next edge plus 1 ns for inputs and sampling
	task automatic advance();
		@(posedge clock);
		#1;
		cycleCount = cycleCount + 1;
		checkDue();
	endtask

	task automatic runStimulus();
		for (int i = 0; i < 3; i++)
		begin
			driveMsg('0, '0, 1'b0, 8'd6, i == 2);
			advance();
		end
		for (int i = 0; i < goldens.size(); i++)
		begin
			driveMsg(goldens[i].stim, goldens[i].want, goldens[i].maskData,
				goldens[i].testNum, 1'b0);
			advance();
			if (i == goldens.size() - 1 || goldens[i + 1].testNum != goldens[i].testNum)
			begin
				driveMsg('0, '0, 1'b0, goldens[i].testNum, 1'b1);	// idle gap
				advance();
			end
		end
		drainCycles = 0;
		while (expQueue.size() > 0 && drainCycles < 20)
		begin
			advance();
			drainCycles++;
		end
		if (expQueue.size() > 0)
		begin
			timedOut = 1'b1;
			$display("timeout: %0d expected messages never reached msgOut", expQueue.size());
		end
	endtask

	initial
	begin
		rst = 1'b1;
		msgIn = '0;
		cycleCount = '0;
		timedOut = 1'b0;
		checkTotal = 0;
		errorTotal = 0;
		loadErrors = 0;
		testsRun = 0;
		testsPassed = 0;
		readGolden();
		repeat (3)
			@(posedge clock);
		#1;
		rst = 1'b0;
		checkDue();
		if (loadErrors == 0)
			runStimulus();
		if (testsRun != 6)
			$display("only %0d of 6 tests ran to the end", testsRun);
		$display("%0d of %0d tests passed, %0d messages checked, %0d mismatches", testsPassed,
			testsRun, checkTotal, errorTotal);
		if (errorTotal == 0 && loadErrors == 0 && !timedOut && testsRun == 6)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== bench/tileRomGolden.txt ====
# test mask | stimulus seq opm addr data | expected seq opm addr data, all hex
# mask 1 skips the data field, used for store replies
1 0 0301 0310 0 0 0301 0360 0 00770066005500440033002200110000
1 0 0302 5a11 50 0 0302 5a60 50 55775566555555445533552255115500
1 0 0303 0c10 f8 0 0303 0c60 f8 ff77ff66ff55ff44ff33ff22ff11ff00
1 0 0304 0214 a0 0 0304 0260 a0 aa77aa66aa55aa44aa33aa22aa11aa00
1 0 0305 0015 30 0 0305 0060 30 33773366335533443333332233113300
1 0 0306 0110 7ff0 dead 0306 0160 7ff0 0
2 1 0401 0112 c000 0123456789abcdef0011223344556677 0401 0161 c000 0
2 0 0402 0110 c000 0 0402 0160 c000 0123456789abcdef0011223344556677
2 1 0403 0213 dff0 fedcba98765432100f1e2d3c4b5a6978 0403 0261 dff0 0
2 1 0404 0912 c010 00000000ffffffff00000000ffffffff 0404 0961 c010 0
2 0 0405 0e11 dff4 0 0405 0e60 dff4 fedcba98765432100f1e2d3c4b5a6978
2 0 0406 0014 c01c 0 0406 0060 c01c 00000000ffffffff00000000ffffffff
2 1 0407 0112 c000 11111111222222223333333344444444 0407 0161 c000 0
2 0 0408 0110 c000 0 0408 0160 c000 11111111222222223333333344444444
3 0 0501 0110 10000 0 0501 0160 10000 0
3 0 0502 0410 1fff0 abcd 0502 0460 1fff0 0
3 0 0503 0110 20000 0 0503 0160 20000 30003000300030003000300030003000
3 0 0504 0214 2abc0 0 0504 0260 2abc0 30003000300030003000300030003000
3 0 0505 0110 30000 0 0505 0160 30000 30103010301030103010301030103010
3 0 0506 0711 3fff0 0 0506 0760 3fff0 30103010301030103010301030103010
4 0 0601 0310 40000000 1234 0601 0b60 40000000 0
4 0 0602 0f12 80000000 5678 0602 0f60 80000000 0
4 0 0603 a514 c0001000 0 0603 ab60 c0001000 0
4 0 0604 0010 ffffff00 0 0604 0b60 ffffff00 0
4 0 0605 0283 1234 cafe 0605 0260 1234 0
4 0 0606 0f8f 0 1 0606 0f60 0 0
4 0 0607 0180 80000000 0 0607 0160 80000000 0
5 0 0 0 0 0 0 0 0 0
5 0 0701 0a00 1234 beef 0701 0a00 1234 beef
5 0 0702 0360 c000 abc 0702 0360 c000 abc
5 0 0703 0561 100 1 0703 0561 100 1
5 0 0704 0110 40000 0 0704 0110 40000 0
5 0 0705 0212 3fffff00 aa 0705 0212 3fffff00 aa
5 0 0706 0110 8000 0 0706 0110 8000 0
5 0 0707 0113 e010 55 0707 0113 e010 55
5 0 0708 0320 c000 99 0708 0320 c000 99

// ==== romImage.hex ====
// one 128-bit tile per line, tile 0 first
00770066005500440033002200110000
11771166115511441133112211111100
22772266225522442233222222112200
33773366335533443333332233113300
44774466445544444433442244114400
55775566555555445533552255115500
66776666665566446633662266116600
77777766775577447733772277117700
88778866885588448833882288118800
99779966995599449933992299119900
aa77aa66aa55aa44aa33aa22aa11aa00
bb77bb66bb55bb44bb33bb22bb11bb00
cc77cc66cc55cc44cc33cc22cc11cc00
dd77dd66dd55dd44dd33dd22dd11dd00
ee77ee66ee55ee44ee33ee22ee11ee00
ff77ff66ff55ff44ff33ff22ff11ff00

// ==== tileRomNode.f ====
hdl/ringPkg.sv
hdl/ringDecode.sv
hdl/tileStore.sv
hdl/ringResult.sv
hdl/tileRomNode.sv
bench/tileRomNodeTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tileRomNode testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tileRomNodeTb -f tileRomNode.f

output=$(./obj_dir/VtileRomNodeTb)
echo "$output"

if echo "$output" | grep -q "^Done: no errors$"; then
	exit 0
else
	exit 1
fi
